// File: vidPostProcess.f
design/vidPkg.sv
design/vidStartFsm.sv
design/vidTimingGen.sv
design/vidPixelFifo.sv
design/vidPixelSerializer.sv
design/vidPostProcess.sv
verif/vidPostProcessChecker.sv
verif/vidPostProcess_asserts.sv
verif/vidPostProcessTb.sv

// File: Bender.yml
package:
  name: vidPostProcess

sources:
  - files:
      - design/vidPkg.sv
      - design/vidStartFsm.sv
      - design/vidTimingGen.sv
      - design/vidPixelFifo.sv
      - design/vidPixelSerializer.sv
      - design/vidPostProcess.sv
  - target: test
    files:
      - verif/vidPostProcessChecker.sv
      - verif/vidPostProcess_asserts.sv
      - verif/vidPostProcessTb.sv

// File: verif/vidPostProcessTb.sv
//--------------------------------------------------
// testbench for the video output stage
// clock, reset, stimulus table, watchdog and the
// final verdict
//--------------------------------------------------
module vidPostProcessTb;

	import vidPkg::*;

	// table layout
	localparam int lpEntries   = 2 * lpFifoDepth + 6;
	localparam int lpBlankIdx  = lpFifoDepth;
	localparam int lpDropIdx   = 2 * lpFifoDepth;
	localparam int lpTailIdx   = lpDropIdx + 1;
	localparam int lpFrameClks = lpHTotal * lpVTotal;
	localparam int lpMargin    = 64;

	logic        iVCLK;
	logic        iVRST;
	tPixelWord   pixelWord;
	logic        pixelVd;
	logic        expDrop;
	logic        finish;
	logic        full;
	logic        hSync;
	logic        vSync;
	logic        de;
	logic [15:0] data;
	logic        underrun;
	int          errCnt;
	int          checkCnt;
	int          gapTab  [lpEntries];
	tPixelWord   wordTab [lpEntries];
	logic        dropTab [lpEntries];
	integer      seed;
	int          tableCycles = 0;

	// 8 unit period
	initial
	begin
		iVCLK = 1'b0;
		forever #4 iVCLK = ~iVCLK;
	end

	vidPostProcess DUT
	(
		.iVCLK       (iVCLK),
		.iVRST       (iVRST),
		.i_pixelWord (pixelWord),
		.i_pixelVd   (pixelVd),
		.o_full      (full),
		.o_hSync     (hSync),
		.o_vSync     (vSync),
		.o_de        (de),
		.o_data      (data),
		.o_underrun  (underrun)
	);

	vidPostProcessChecker uChecker
	(
		.iVCLK       (iVCLK),
		.iVRST       (iVRST),
		.i_pixelWord (pixelWord),
		.i_pixelVd   (pixelVd),
		.i_expDrop   (expDrop),
		.i_full      (full),
		.i_hSync     (hSync),
		.i_vSync     (vSync),
		.i_de        (de),
		.i_data      (data),
		.i_underrun  (underrun),
		.i_finish    (finish),
		.o_errCnt    (errCnt),
		.o_checkCnt  (checkCnt)
	);

	//--------------------------------------------------
	// stimulus table
	//--------------------------------------------------
	task automatic buildTable();
		for (int i = 0; i < lpEntries; i++)
		begin
			wordTab[i] = $random(seed);
			gapTab[i]  = 0;
			dropTab[i] = 1'b0;
		end
		// one word short of a line, then two idle frames
		for (int i = 0; i < lpStartWords - 1; i++)
			gapTab[i] = 2;
		gapTab[lpStartWords - 1] = 2 * lpFrameClks;
		// rest of frame 0 back to back
		// next burst lands in the middle of the vertical blank
		gapTab[lpBlankIdx] = 95;
		// fifo full by now, word is lost
		dropTab[lpDropIdx] = 1'b1;
		// a few words after frame 1 so frame 2 runs dry mid line
		gapTab[lpTailIdx] = 147;
		tableCycles = 5;
		for (int i = 0; i < lpEntries; i++)
			tableCycles += gapTab[i] + 1;
	endtask

	//--------------------------------------------------
	// main sequence
	//--------------------------------------------------
	initial
	begin
		iVRST     = 1'b1;
		pixelVd   = 1'b0;
		pixelWord = '0;
		expDrop   = 1'b0;
		finish    = 1'b0;
		seed      = 32'he75178c3;
		buildTable();
		repeat (5) @(negedge iVCLK);
		iVRST = 1'b0;
		for (int i = 0; i < lpEntries; i++)
		begin
			repeat (gapTab[i])
			begin
				@(negedge iVCLK);
				pixelVd = 1'b0;
				expDrop = 1'b0;
			end
			@(negedge iVCLK);
			pixelVd   = 1'b1;
			pixelWord = wordTab[i];
			expDrop   = dropTab[i];
		end
		@(negedge iVCLK);
		pixelVd = 1'b0;
		expDrop = 1'b0;
		// drained fifo shows as underrun, then one more vsync
		wait (underrun === 1'b1);
		@(posedge vSync);
		repeat (4) @(negedge iVCLK);
		finish = 1'b1;
		@(posedge iVCLK);
		$display("summary: 5 tests, %0d checks, %0d errors, %0d assertion failures",
			checkCnt, errCnt, DUT.uAsserts.failCnt);
		if ((errCnt == 0) && (DUT.uAsserts.failCnt == 0))
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// watchdog, table length plus three frames
	initial
	begin
		wait (tableCycles > 0);
		repeat (tableCycles + 3 * lpFrameClks + lpMargin) @(posedge iVCLK);
		$display("timeout: no verdict after %0d cycles",
			tableCycles + 3 * lpFrameClks + lpMargin);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// File: verif/vidPostProcess_asserts.sv
//--------------------------------------------------
// concurrent checks on the top level outputs
// bound into the video output stage
//--------------------------------------------------
module vidPostProcess_asserts
(
	input logic iVCLK,
	input logic iVRST,
	input logic i_hSync,
	input logic i_de,
	input logic i_underrun
);

	import vidPkg::*;

	// failed assertion count
	int failCnt = 0;

	// hsync sits inside horizontal blanking
	deOutsideSync: assert property (@(posedge iVCLK) disable iff (iVRST)
		!(i_de && i_hSync))
	else
	begin
		$error("o_de high while o_hSync is high");
		failCnt++;
	end

	// pulse width in pixel clocks
	hSyncWidth: assert property (@(posedge iVCLK) disable iff (iVRST)
		$rose(i_hSync) |-> i_hSync[*lpHSync] ##1 !i_hSync)
	else
	begin
		$error("o_hSync pulse width differs from the line geometry");
		failCnt++;
	end

	// sticky flag, only reset clears it
	underrunSticky: assert property (@(posedge iVCLK)
		$fell(i_underrun) |-> $past(iVRST))
	else
	begin
		$error("o_underrun fell without a reset");
		failCnt++;
	end

endmodule

bind vidPostProcess vidPostProcess_asserts uAsserts
(
	.iVCLK      (iVCLK),
	.iVRST      (iVRST),
	.i_hSync    (o_hSync),
	.i_de       (o_de),
	.i_underrun (o_underrun)
);

// File: verif/vidPostProcessChecker.sv
//--------------------------------------------------
// checker for the video output stage
// queue of written words, raster and pixel
// prediction, per test error counts
//--------------------------------------------------
module vidPostProcessChecker
(
	input  logic              iVCLK,
	input  logic              iVRST,
	input  vidPkg::tPixelWord i_pixelWord,
	input  logic              i_pixelVd,
	input  logic              i_expDrop,
	input  logic              i_full,
	input  logic              i_hSync,
	input  logic              i_vSync,
	input  logic              i_de,
	input  logic [15:0]       i_data,
	input  logic              i_underrun,
	input  logic              i_finish,
	output int                o_errCnt,
	output int                o_checkCnt
);

	import vidPkg::*;

	logic [15:0] pixQ [$];
	int          errs [1:5];
	int          wrCnt;
	int          accWords;
	int          shownPix;
	int          pos;
	int          hPos;
	int          line;
	logic        expDe;
	logic        expHs;
	logic        expVs;
	logic        seenRst = 1'b0;
	logic        started = 1'b0;
	logic        holdDone = 1'b0;
	logic        fullDone = 1'b0;
	logic        fullQ = 1'b0;
	logic        urQ = 1'b0;

	assign o_errCnt = errs[1] + errs[2] + errs[3] + errs[4] + errs[5];

	task automatic compareValue(input int test, input string name,
		input logic [15:0] exp, input logic [15:0] got);
		o_checkCnt++;
		if (got !== exp)
		begin
			$display("mismatch t=%0t %s expected %h got %h", $time, name, exp, got);
			errs[test]++;
		end
	endtask

	task automatic reportError(input int test, input string msg);
		$display("error t=%0t test %0d: %s", $time, test, msg);
		errs[test]++;
	endtask

	task automatic printTestLine(input int test, input string name);
		$display("test %0d %s: %0d errors", test, name, errs[test]);
	endtask

	//--------------------------------------------------
	// write side, inputs settle on the falling edge
	//--------------------------------------------------
	always @(posedge iVCLK)
	begin
		if (iVRST)
			seenRst = 1'b1;
		else if (i_pixelVd)
		begin
			wrCnt++;
			// full as shown before this edge decides the drop
			compareValue(4, "o_full", 16'(i_expDrop), 16'(fullQ));
			if (!i_expDrop)
			begin
				accWords++;
				// pixel 0 low, luma moves to the high byte
				pixQ.push_back({i_pixelWord.raw[7:0], i_pixelWord.raw[15:8]});
				pixQ.push_back({i_pixelWord.raw[23:16], i_pixelWord.raw[31:24]});
			end
		end
	end

	//--------------------------------------------------
	// output side, sampled mid cycle
	//--------------------------------------------------
	always @(negedge iVCLK)
	begin
		if (seenRst && (wrCnt < lpStartWords))
		begin
			// raster held, everything at rest
			compareValue(1, "o_de", 16'd0, 16'(i_de));
			compareValue(1, "o_hSync", 16'd0, 16'(i_hSync));
			compareValue(1, "o_vSync", 16'd0, 16'(i_vSync));
			compareValue(1, "o_full", 16'd0, 16'(i_full));
			compareValue(1, "o_underrun", 16'd0, 16'(i_underrun));
			compareValue(1, "o_data", 16'd0, i_data);
		end
		else if (seenRst)
		begin
			if (!holdDone)
				printTestLine(1, "start-up hold");
			holdDone = 1'b1;
			// frame origin is the first de
			if (i_de && !started)
				started = 1'b1;
			if (started)
			begin
				hPos  = pos % lpHTotal;
				line  = pos / lpHTotal;
				expDe = (hPos < lpHActive) && (line < lpVActive);
				expHs = (hPos >= lpHActive + lpHFront) &&
					(hPos < lpHActive + lpHFront + lpHSync);
				expVs = (line >= lpVActive + lpVFront) &&
					(line < lpVActive + lpVFront + lpVSync);
				compareValue(2, "o_de", 16'(expDe), 16'(i_de));
				compareValue(2, "o_hSync", 16'(expHs), 16'(i_hSync));
				compareValue(2, "o_vSync", 16'(expVs), 16'(i_vSync));
				pos = (pos + 1) % (lpHTotal * lpVTotal);
			end
			// pixels in write order until the queue runs out
			if (i_de && (pixQ.size() > 0))
			begin
				compareValue(3, "o_data", pixQ.pop_front(), i_data);
				shownPix++;
			end
			if (i_full && !fullQ && (accWords - shownPix / 2 != lpFifoDepth))
				reportError(4, "o_full rose before the fifo held a full set of words");
			if (!i_full && fullQ && !fullDone)
			begin
				fullDone = 1'b1;
				printTestLine(4, "full and drop");
			end
			if (i_underrun && !urQ && (pixQ.size() != 0))
				reportError(5, $sformatf("o_underrun rose with %0d pixels due", pixQ.size()));
			if (!i_underrun && urQ)
				reportError(5, "o_underrun fell without a reset");
		end
		fullQ = i_full;
		urQ   = i_underrun;
	end

	// end of run
	always @(posedge i_finish)
	begin
		if (!started)
			reportError(2, "o_de never rose");
		if (pixQ.size() != 0)
			reportError(3, $sformatf("%0d written pixels never reached o_data", pixQ.size()));
		if (!fullDone)
		begin
			reportError(4, "o_full never rose and fell again");
			printTestLine(4, "full and drop");
		end
		if (!urQ)
			reportError(5, "o_underrun never rose after the fifo drained");
		printTestLine(2, "raster timing");
		printTestLine(3, "pixel order");
		printTestLine(5, "underrun");
	end

endmodule

// File: design/vidPostProcess.sv
//--------------------------------------------------
// video output stage top level
// start-up fsm, raster timing, pixel fifo and
// serializer on one video clock
//--------------------------------------------------
module vidPostProcess
(
	input  logic             iVCLK,
	input  logic             iVRST,
	input  vidPkg::tPixelWord i_pixelWord,
	input  logic             i_pixelVd,
	output logic             o_full,
	output logic             o_hSync,
	output logic             o_vSync,
	output logic             o_de,
	output logic [15:0]      o_data,
	output logic             o_underrun
);

	import vidPkg::*;

	logic      fifoFull;
	logic      fifoEmpty;
	logic      fifoRe;
	logic      genRst;
	logic      fetch;
	tPixelWord rdWord;

	// overflow shown only as full
	assign o_full = fifoFull;

	// holds raster until a line is buffered
	vidStartFsm uStartFsm
	(
		.iVCLK       (iVCLK),
		.iVRST       (iVRST),
		.i_pixelVd   (i_pixelVd),
		.i_fifoRe    (fifoRe),
		.i_fifoEmpty (fifoEmpty),
		.o_genRst    (genRst),
		.o_underrun  (o_underrun)
	);

	vidTimingGen uTimingGen
	(
		.iVCLK    (iVCLK),
		.iVRST    (iVRST),
		.i_genRst (genRst),
		.o_hSync  (o_hSync),
		.o_vSync  (o_vSync),
		.o_de     (o_de),
		.o_fetch  (fetch)
	);

	// word buffer between capture and raster
	vidPixelFifo uPixelFifo
	(
		.iVCLK   (iVCLK),
		.iVRST   (iVRST),
		.i_we    (i_pixelVd),
		.i_wd    (i_pixelWord),
		.i_re    (fifoRe),
		.o_rd    (rdWord),
		.o_full  (fifoFull),
		.o_empty (fifoEmpty)
	);

	vidPixelSerializer uPixelSerializer
	(
		.iVCLK   (iVCLK),
		.iVRST   (iVRST),
		.i_fetch (fetch),
		.i_rd    (rdWord),
		.o_re    (fifoRe),
		.o_data  (o_data)
	);

endmodule

// File: design/vidPixelSerializer.sv
//--------------------------------------------------
// word to pixel serializer
// one fifo read per pixel pair, luma and chroma
// bytes swapped for the hdmi transmitter
//--------------------------------------------------
module vidPixelSerializer
(
	input  logic             iVCLK,
	input  logic             iVRST,
	input  logic             i_fetch,
	input  vidPkg::tPixelWord i_rd,
	output logic             o_re,
	output logic [15:0]      o_data
);

	import vidPkg::*;

	logic             phase;
	logic             rdVd;
	logic             hiPend;
	logic [1:0][7:0]  holdPix;

	// luma to the high byte, chroma to the low byte
	function automatic logic [15:0] fSwap(input logic [1:0][7:0] p);
		return {p[lpYIdx], p[lpCIdx]};
	endfunction

	// read on even pixels of the fetch window
	assign o_re = i_fetch & ~phase;

	//--------------------------------------------------
	// phase and read tracking
	//--------------------------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			phase  <= 1'b0;
			rdVd   <= 1'b0;
			hiPend <= 1'b0;
		end
		else
		begin
			phase  <= i_fetch ? ~phase : 1'b0;
			// fifo data is valid one cycle after the read
			rdVd   <= o_re;
			hiPend <= rdVd;
		end
	end

	// second pixel waits one cycle
	always_ff @(posedge iVCLK)
	begin
		if (rdVd)
			holdPix <= i_rd.pix[1];
	end

	//--------------------------------------------------
	// pixel output, lines up with de
	//--------------------------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
			o_data <= '0;
		else if (rdVd)
			o_data <= fSwap(i_rd.pix[0]);
		else if (hiPend)
			o_data <= fSwap(holdPix);
		else
			o_data <= '0;
	end

endmodule

// File: design/vidPixelFifo.sv
//--------------------------------------------------
// single clock pixel word fifo
// circular buffer with fill count, drops writes
// when full, registered read data
//--------------------------------------------------
module vidPixelFifo
(
	input  logic             iVCLK,
	input  logic             iVRST,
	input  logic             i_we,
	input  vidPkg::tPixelWord i_wd,
	input  logic             i_re,
	output vidPkg::tPixelWord o_rd,
	output logic             o_full,
	output logic             o_empty
);

	import vidPkg::*;

	tPixelWord             mem [lpFifoDepth];
	logic [lpFifoAw-1:0]   wrPtr;
	logic [lpFifoAw-1:0]   rdPtr;
	logic [lpFifoCw-1:0]   fillCnt;
	logic                  wrOk;
	logic                  rdOk;

	// flags from the fill count
	assign o_full  = (fillCnt == lpFifoCw'(lpFifoDepth));
	assign o_empty = (fillCnt == '0);

	// accepted transfers only
	assign wrOk = i_we & ~o_full;
	assign rdOk = i_re & ~o_empty;

	//--------------------------------------------------
	// storage and read port
	//--------------------------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (wrOk)
			mem[wrPtr] <= i_wd;
		// empty read leaves the last word on o_rd
		if (rdOk)
			o_rd <= mem[rdPtr];
	end

	//--------------------------------------------------
	// pointers and fill count
	//--------------------------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			fillCnt <= '0;
		end
		else
		begin
			// depth is a power of two, pointers wrap freely
			if (wrOk)
				wrPtr <= wrPtr + 1'b1;
			if (rdOk)
				rdPtr <= rdPtr + 1'b1;
			case ({wrOk, rdOk})
				2'b10:   fillCnt <= fillCnt + 1'b1;
				2'b01:   fillCnt <= fillCnt - 1'b1;
				default: fillCnt <= fillCnt;
			endcase
		end
	end

endmodule

// File: design/vidTimingGen.sv
//--------------------------------------------------
// raster timing generator
// horizontal and vertical counters, sync and de
// regions, early fetch strobe and the output
// pipeline that puts de behind the fetch
//--------------------------------------------------
module vidTimingGen
(
	input  logic iVCLK,
	input  logic iVRST,
	input  logic i_genRst,
	output logic o_hSync,
	output logic o_vSync,
	output logic o_de,
	output logic o_fetch
);

	import vidPkg::*;

	logic                  genClr;
	logic [lpHWidth-1:0]   hCnt;
	logic [lpVWidth-1:0]   vCnt;
	logic                  hEnd;
	logic                  vEnd;
	logic                  actReg;
	logic                  hsReg;
	logic                  vsReg;
	logic [lpFetchLead-1:0] dePipe;
	logic [lpFetchLead-1:0] hsPipe;
	logic [lpFetchLead-1:0] vsPipe;

	// either reset keeps the raster parked at origin
	assign genClr = iVRST | i_genRst;

	assign hEnd = (hCnt == lpHWidth'(lpHTotal - 1));
	assign vEnd = (vCnt == lpVWidth'(lpVTotal - 1));

	//--------------------------------------------------
	// counters
	//--------------------------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (genClr)
		begin
			hCnt <= '0;
			vCnt <= '0;
		end
		else
		begin
			// pixel counter, wraps at line total
			hCnt <= hEnd ? '0 : hCnt + 1'b1;
			// line counter steps at end of each line
			if (hEnd)
				vCnt <= vEnd ? '0 : vCnt + 1'b1;
		end
	end

	//--------------------------------------------------
	// region decode, first register stage
	//--------------------------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (genClr)
		begin
			actReg <= 1'b0;
			hsReg  <= 1'b0;
			vsReg  <= 1'b0;
		end
		else
		begin
			// active order: active, front, sync, back
			actReg <= (hCnt < lpHWidth'(lpHActive)) && (vCnt < lpVWidth'(lpVActive));
			hsReg  <= (hCnt >= lpHWidth'(lpHSyncBeg)) && (hCnt < lpHWidth'(lpHSyncEnd));
			// vcnt moves only at line start, so vsync does too
			vsReg  <= (vCnt >= lpVWidth'(lpVSyncBeg)) && (vCnt < lpVWidth'(lpVSyncEnd));
		end
	end

	// fetch straight from the region register
	assign o_fetch = actReg;

	//--------------------------------------------------
	// delay pipeline, de trails fetch by lpFetchLead
	//--------------------------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (genClr)
		begin
			dePipe <= '0;
			hsPipe <= '0;
			vsPipe <= '0;
		end
		else
		begin
			dePipe <= {dePipe[lpFetchLead-2:0], actReg};
			hsPipe <= {hsPipe[lpFetchLead-2:0], hsReg};
			vsPipe <= {vsPipe[lpFetchLead-2:0], vsReg};
		end
	end

	// pipeline tails
	assign o_de    = dePipe[lpFetchLead-1];
	assign o_hSync = hsPipe[lpFetchLead-1];
	assign o_vSync = vsPipe[lpFetchLead-1];

endmodule

// File: design/vidStartFsm.sv
//--------------------------------------------------
// start-up control for the raster generator
// holds the raster until a line of words is
// buffered, then releases it through a short
// reset chain; latches fifo underrun
//--------------------------------------------------
module vidStartFsm
(
	input  logic iVCLK,
	input  logic iVRST,
	input  logic i_pixelVd,
	input  logic i_fifoRe,
	input  logic i_fifoEmpty,
	output logic o_genRst,
	output logic o_underrun
);

	import vidPkg::*;

	logic [1:0]            state;
	logic [lpStartCw-1:0]  wordCnt;
	logic [lpRstChain-1:0] rstChain;

	//--------------------------------------------------
	// state and word count
	//--------------------------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			state    <= lpStHold;
			wordCnt  <= '0;
			rstChain <= '1;
		end
		else
		begin
			case (state)
				lpStHold:
				begin
					// count strobes, arm on the last one
					if (i_pixelVd)
					begin
						wordCnt <= wordCnt + 1'b1;
						if (wordCnt == lpStartCw'(lpStartWords - 1))
							state <= lpStArm;
					end
				end
				lpStArm:
				begin
					// shift zeros in, run once the chain is clear
					rstChain <= {rstChain[lpRstChain-2:0], 1'b0};
					if (rstChain[lpRstChain-2:0] == '0)
						state <= lpStRun;
				end
				default:
				begin
					// run, nothing left to do until next reset
					state <= lpStRun;
				end
			endcase
		end
	end

	// raster reset from the chain tail
	assign o_genRst = rstChain[lpRstChain-1];

	//--------------------------------------------------
	// sticky underrun flag
	//--------------------------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
			o_underrun <= 1'b0;
		else if ((state == lpStRun) && i_fifoRe && i_fifoEmpty)
			o_underrun <= 1'b1;
	end

endmodule

// File: design/vidPkg.sv
//--------------------------------------------------
// shared definitions for the video output stage
// raster geometry, fifo sizing, start-up control
// and the packed yuyv pixel word
//--------------------------------------------------
package vidPkg;

	//--------------------------------------------------
	// line geometry in pixels, one pixel per clock
	//--------------------------------------------------
	localparam int lpHActive   = 16;
	localparam int lpHFront    = 2;
	localparam int lpHSync     = 2;
	localparam int lpHBack     = 4;
	localparam int lpHTotal    = lpHActive + lpHFront + lpHSync + lpHBack;
	// hsync window, end exclusive
	localparam int lpHSyncBeg  = lpHActive + lpHFront;
	localparam int lpHSyncEnd  = lpHSyncBeg + lpHSync;
	localparam int lpHWidth    = $clog2(lpHTotal);

	//--------------------------------------------------
	// frame geometry in lines
	//--------------------------------------------------
	localparam int lpVActive   = 4;
	localparam int lpVFront    = 1;
	localparam int lpVSync     = 1;
	localparam int lpVBack     = 2;
	localparam int lpVTotal    = lpVActive + lpVFront + lpVSync + lpVBack;
	localparam int lpVSyncBeg  = lpVActive + lpVFront;
	localparam int lpVSyncEnd  = lpVSyncBeg + lpVSync;
	localparam int lpVWidth    = $clog2(lpVTotal);

	//--------------------------------------------------
	// pixel fifo and start-up control
	//--------------------------------------------------
	localparam int lpFifoDepth  = 32;
	localparam int lpFifoAw     = $clog2(lpFifoDepth);
	// count needs one extra code for full
	localparam int lpFifoCw     = $clog2(lpFifoDepth + 1);
	// one active line, two pixels per word
	localparam int lpStartWords = 8;
	localparam int lpStartCw    = $clog2(lpStartWords + 1);
	// stages between arm and raster release
	localparam int lpRstChain   = 3;
	// fetch strobe runs ahead of de by this much
	localparam int lpFetchLead  = 2;

	// start-up fsm encodings
	localparam logic [1:0] lpStHold = 2'd0;
	localparam logic [1:0] lpStArm  = 2'd1;
	localparam logic [1:0] lpStRun  = 2'd2;

	// byte positions inside one 16-bit yuyv pixel
	localparam int lpYIdx = 0;
	localparam int lpCIdx = 1;

	// one fifo word, raw or as two pixels
	// pix[0] is the low 16 bits, pix[n][lpYIdx] the luma byte
	typedef union packed
	{
		logic [31:0]           raw;
		logic [1:0][1:0][7:0]  pix;
	} tPixelWord;

endpackage
